//--- hdl/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Memory geometry
`define MEM_ADDR_W 6      // Word index, 64 words
`define MEM_DATA_W 46     // Stored word
`define MEM_LANES  6      // Byte macros per word
`define LANE_W     8      // One macro

// Upper part of a word, reached through the high half address
`define HI_W       14

// APB side
`define APB_ADDR_W 12
`define APB_DATA_W 32

`endif

//--- hdl/mem_pkg.sv
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

  // Index of one 46-bit word
  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

  // Full stored word, spread over six macros
  typedef logic [`MEM_DATA_W-1:0] mem_word_t;

  // Bits 45:32, staged on writes and held on reads
  typedef logic [`HI_W-1:0] mem_hi_t;

  // One enable per byte macro
  // Bit 5 covers the partly used sixth macro
  typedef logic [`MEM_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

//--- hdl/apb_pkg.sv
`default_nettype none

`include "mem_macros.svh"

package apb_pkg;

  typedef logic [`APB_ADDR_W-1:0]   apb_addr_t;  // PADDR
  typedef logic [`APB_DATA_W-1:0]   apb_data_t;  // PWDATA and PRDATA
  typedef logic [`APB_DATA_W/8-1:0] apb_strb_t;  // PSTRB

  // What one APB access does to the memory
  typedef enum logic [2:0] {
    ACC_WR_LO,  // Commit staged upper part with low data
    ACC_WR_HI,  // Stage upper part only
    ACC_RD_LO,  // Macro read, latch upper part
    ACC_RD_HI,  // Return latched upper part
    ACC_ERR     // Bad address
  } access_kind_e;

  // Execute FSM
  typedef enum logic [1:0] {
    EX_IDLE,
    EX_ISSUE,
    EX_WAIT,
    EX_DONE
  } exec_state_e;

endpackage

`default_nettype wire

//--- hdl/synthram_64x8.sv
`default_nettype none

`include "mem_macros.svh"

module synthram_64x8 (
  input  logic                clk_i,
  input  logic                ce_i,      // Chip enable, active high
  input  logic                we_i,      // Write enable, active high
  input  logic [`LANE_W-1:0]  w_mask_i,  // Per-bit write enable
  input  mem_pkg::mem_addr_t  addr_i,
  input  logic [`LANE_W-1:0]  wd_i,
  output logic [`LANE_W-1:0]  rd_o
);

  localparam int DEPTH = 1 << `MEM_ADDR_W;

  logic [`LANE_W-1:0] mem [DEPTH];

  // Masked write, only the enabled bits change
  always_ff @(posedge clk_i) begin
    if (ce_i && we_i) begin
      mem[addr_i] <= (mem[addr_i] & ~w_mask_i) | (wd_i & w_mask_i);
    end
  end

  // Registered read port
  // rd_o keeps the last read value until the next read
  always_ff @(posedge clk_i) begin
    if (ce_i && !we_i) begin
      rd_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- hdl/hard_mem_1rw_d64_w46_wrapper.sv
`default_nettype none

`include "mem_macros.svh"

module hard_mem_1rw_d64_w46_wrapper (
  input  wire                      clk_i,
  input  wire                      v_i,           // Access enable, active high
  input  wire                      w_i,           // Write, active high
  input  mem_pkg::mem_addr_t       addr_i,
  input  mem_pkg::mem_word_t       data_i,
  input  mem_pkg::lane_mask_t      write_mask_i,  // One bit per macro
  output wire mem_pkg::mem_word_t  data_o
);

  // Bits that land in the sixth macro
  localparam int TOP_W = `MEM_DATA_W - (`MEM_LANES - 1) * `LANE_W;
  localparam int LAST  = `MEM_LANES - 1;

  wire [`LANE_W-1:0] wd_lane [`MEM_LANES];
  wire [`LANE_W-1:0] rd_lane [`MEM_LANES];

  genvar g;

  // Five full byte lanes
  for (g = 0; g < LAST; g++) begin : g_full
    assign wd_lane[g]                = data_i[g*`LANE_W +: `LANE_W];
    assign data_o[g*`LANE_W +: `LANE_W] = rd_lane[g];
  end

  // Sixth lane carries bits 45:40, upper macro bits tied to zero
  assign wd_lane[LAST] = {{(`LANE_W - TOP_W){1'b0}}, data_i[`MEM_DATA_W-1 -: TOP_W]};
  assign data_o[`MEM_DATA_W-1 -: TOP_W] = rd_lane[LAST][TOP_W-1:0];

  for (g = 0; g < `MEM_LANES; g++) begin : g_lane
    synthram_64x8 u_ram (
      .clk_i    (clk_i),
      .ce_i     (v_i),
      .we_i     (w_i),
      .w_mask_i ({`LANE_W{write_mask_i[g]}}),  // Lane bit over all 8 bits
      .addr_i   (addr_i),
      .wd_i     (wd_lane[g]),
      .rd_o     (rd_lane[g])
    );
  end

  // A write outside an enabled cycle would be silently dropped by the macros
  a_write_needs_valid : assert property (@(posedge clk_i) w_i |-> v_i)
    else $error("wrapper write without v_i");

endmodule

`default_nettype wire

//--- hdl/apb_mem_decode.sv
`default_nettype none

`include "mem_macros.svh"

module apb_mem_decode (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  apb_pkg::apb_addr_t     paddr_i,
  input  apb_pkg::apb_data_t     pwdata_i,
  input  apb_pkg::apb_strb_t     pstrb_i,
  input  logic                   pready_i,     // Completion from result block
  output logic                   acc_valid_o,
  output apb_pkg::access_kind_e  acc_kind_o,
  output mem_pkg::mem_addr_t     acc_addr_o,
  output apb_pkg::apb_data_t     acc_wdata_o,
  output apb_pkg::apb_strb_t     acc_strb_o
);

  logic                  armed_q;   // Set until the access phase is taken
  logic                  fire;
  logic                  addr_err;
  apb_pkg::access_kind_e kind;

  assign fire = psel_i && penable_i && armed_q;

  // Low two bits and bits 11:9 must be zero
  assign addr_err = (paddr_i[1:0] != 2'b00) || (paddr_i[`APB_ADDR_W-1:9] != '0);

  always_comb begin
    if (addr_err) begin
      kind = apb_pkg::ACC_ERR;
    end else if (pwrite_i) begin
      if (paddr_i[2]) kind = apb_pkg::ACC_WR_HI;
      else            kind = apb_pkg::ACC_WR_LO;
    end else begin
      if (paddr_i[2]) kind = apb_pkg::ACC_RD_HI;
      else            kind = apb_pkg::ACC_RD_LO;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      armed_q     <= 1'b1;
      acc_valid_o <= 1'b0;
    end else begin
      acc_valid_o <= fire;  // One pulse per transfer
      if (fire) begin
        armed_q <= 1'b0;
      end else if (!psel_i || pready_i) begin
        armed_q <= 1'b1;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (fire) begin
      acc_kind_o  <= kind;
      acc_addr_o  <= paddr_i[8:3];
      acc_wdata_o <= pwdata_i;
      acc_strb_o  <= pstrb_i;
    end
  end

  a_penable_with_psel : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) penable_i |-> psel_i
  ) else $error("PENABLE high without PSEL");

endmodule

`default_nettype wire

//--- hdl/mem_access_exec.sv
`default_nettype none

`include "mem_macros.svh"

module mem_access_exec (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   acc_valid_i,
  input  apb_pkg::access_kind_e  acc_kind_i,
  input  mem_pkg::mem_addr_t     acc_addr_i,
  input  apb_pkg::apb_data_t     acc_wdata_i,
  input  apb_pkg::apb_strb_t     acc_strb_i,
  output logic                   mem_v_o,
  output logic                   mem_w_o,
  output mem_pkg::mem_addr_t     mem_addr_o,
  output mem_pkg::mem_word_t     mem_data_o,
  output mem_pkg::lane_mask_t    mem_mask_o,
  output logic                   done_o,
  output apb_pkg::access_kind_e  done_kind_o
);

  // Lanes above the four PSTRB lanes
  localparam int HI_LANES = `MEM_LANES - `APB_DATA_W / 8;

  apb_pkg::exec_state_e  state_q;
  apb_pkg::exec_state_e  state_d;
  apb_pkg::exec_state_e  phase;      // Accept cycle seen as the issue phase
  apb_pkg::access_kind_e kind_q;
  mem_pkg::mem_hi_t      stage_hi_q;
  logic [HI_LANES-1:0]   stage_mask_q;
  logic                  issue;
  logic                  lo_wr;
  logic                  lo_rd;

  assign issue = (state_q == apb_pkg::EX_IDLE) && acc_valid_i;
  assign phase = issue ? apb_pkg::EX_ISSUE : state_q;
  assign lo_wr = issue && (acc_kind_i == apb_pkg::ACC_WR_LO);
  assign lo_rd = issue && (acc_kind_i == apb_pkg::ACC_RD_LO);

  always_comb begin
    state_d = state_q;
    case (phase)
      apb_pkg::EX_IDLE:  state_d = apb_pkg::EX_IDLE;
      apb_pkg::EX_ISSUE: state_d = lo_rd ? apb_pkg::EX_WAIT : apb_pkg::EX_DONE;
      apb_pkg::EX_WAIT:  state_d = apb_pkg::EX_DONE;  // Macro read data settles
      apb_pkg::EX_DONE:  state_d = apb_pkg::EX_IDLE;
      default:           state_d = apb_pkg::EX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= apb_pkg::EX_IDLE;
      kind_q       <= apb_pkg::ACC_ERR;
      stage_hi_q   <= '0;
      stage_mask_q <= '0;
    end else begin
      state_q <= state_d;
      if (issue) kind_q <= acc_kind_i;
      if (issue && (acc_kind_i == apb_pkg::ACC_WR_HI)) begin
        stage_hi_q   <= acc_wdata_i[`HI_W-1:0];
        stage_mask_q <= acc_strb_i[HI_LANES-1:0];
      end else if (lo_wr) begin
        stage_mask_q <= '0;  // Staged data stays, only its lanes are spent
      end
    end
  end

  // Macro cycle goes out in the accept cycle
  assign mem_v_o    = lo_wr || lo_rd;
  assign mem_w_o    = lo_wr;
  assign mem_addr_o = acc_addr_i;
  assign mem_data_o = {stage_hi_q, acc_wdata_i};
  assign mem_mask_o = lo_wr ? {stage_mask_q, acc_strb_i} : '0;

  assign done_o      = (state_q == apb_pkg::EX_DONE);
  assign done_kind_o = kind_q;

  // Decode must hold off until the previous transfer has finished
  a_req_only_idle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) acc_valid_i |-> state_q == apb_pkg::EX_IDLE
  ) else $error("request while execute busy");

endmodule

`default_nettype wire

//--- hdl/apb_mem_result.sv
`default_nettype none

`include "mem_macros.svh"

module apb_mem_result (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   done_i,
  input  apb_pkg::access_kind_e  done_kind_i,
  input  mem_pkg::mem_word_t     mem_rdata_i,  // Valid when a low read is done
  output apb_pkg::apb_data_t     prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  localparam int PAD_W = `APB_DATA_W - `HI_W;

  mem_pkg::mem_hi_t hold_q;  // Upper bits of the last low-half read
  logic             rd_lo;
  logic             rd_hi;

  assign rd_lo = done_i && (done_kind_i == apb_pkg::ACC_RD_LO);
  assign rd_hi = done_i && (done_kind_i == apb_pkg::ACC_RD_HI);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_q <= '0;
    end else if (rd_lo) begin
      hold_q <= mem_rdata_i[`MEM_DATA_W-1:`APB_DATA_W];
    end
  end

  // Read data only during the completing cycle
  always_comb begin
    prdata_o = '0;
    if (rd_lo) begin
      prdata_o = mem_rdata_i[`APB_DATA_W-1:0];
    end else if (rd_hi) begin
      prdata_o = {{PAD_W{1'b0}}, hold_q};
    end
  end

  assign pready_o  = done_i;  // Single cycle pulse
  assign pslverr_o = done_i && (done_kind_i == apb_pkg::ACC_ERR);

endmodule

`default_nettype wire

//--- hdl/apb_mem_top.sv
`default_nettype none

module apb_mem_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  apb_pkg::apb_addr_t  paddr_i,
  input  apb_pkg::apb_data_t  pwdata_i,
  input  apb_pkg::apb_strb_t  pstrb_i,
  output apb_pkg::apb_data_t  prdata_o,
  output logic                pready_o,
  output logic                pslverr_o
);

  // Decode to execute
  logic                  acc_valid;
  apb_pkg::access_kind_e acc_kind;
  mem_pkg::mem_addr_t    acc_addr;
  apb_pkg::apb_data_t    acc_wdata;
  apb_pkg::apb_strb_t    acc_strb;

  // Execute to wrapper and result
  logic                  mem_v;
  logic                  mem_w;
  mem_pkg::mem_addr_t    mem_addr;
  mem_pkg::mem_word_t    mem_wdata;
  mem_pkg::lane_mask_t   mem_mask;
  mem_pkg::mem_word_t    mem_rdata;
  logic                  done;
  apb_pkg::access_kind_e done_kind;

  apb_mem_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .pready_i    (pready_o),  // Re-arms decode
    .acc_valid_o (acc_valid),
    .acc_kind_o  (acc_kind),
    .acc_addr_o  (acc_addr),
    .acc_wdata_o (acc_wdata),
    .acc_strb_o  (acc_strb)
  );

  mem_access_exec u_exec (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .acc_valid_i (acc_valid),
    .acc_kind_i  (acc_kind),
    .acc_addr_i  (acc_addr),
    .acc_wdata_i (acc_wdata),
    .acc_strb_i  (acc_strb),
    .mem_v_o     (mem_v),
    .mem_w_o     (mem_w),
    .mem_addr_o  (mem_addr),
    .mem_data_o  (mem_wdata),
    .mem_mask_o  (mem_mask),
    .done_o      (done),
    .done_kind_o (done_kind)
  );

  hard_mem_1rw_d64_w46_wrapper u_mem (
    .clk_i        (clk_i),
    .v_i          (mem_v),
    .w_i          (mem_w),
    .addr_i       (mem_addr),
    .data_i       (mem_wdata),
    .write_mask_i (mem_mask),
    .data_o       (mem_rdata)
  );

  apb_mem_result u_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .done_i      (done),
    .done_kind_i (done_kind),
    .mem_rdata_i (mem_rdata),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o)
  );

endmodule

`default_nettype wire

//--- test/tb_apb_mem.sv
`default_nettype none

`include "mem_macros.svh"

module tb_apb_mem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS      = 1 << `MEM_ADDR_W;
  localparam int PAD_W      = `APB_DATA_W - `HI_W;
  localparam int N_INIT     = 2 * WORDS;  // One high and one low write per word
  localparam int N_DIRECTED = 32;         // Upper bound
  localparam int N_RANDOM   = 400;
  localparam int MAX_CYCLES = (N_INIT + N_DIRECTED + N_RANDOM) * 6 + 100;

  logic               clk_i;
  logic               rst_n_i;
  logic               psel_i;
  logic               penable_i;
  logic               pwrite_i;
  apb_pkg::apb_addr_t paddr_i;
  apb_pkg::apb_data_t pwdata_i;
  apb_pkg::apb_strb_t pstrb_i;
  apb_pkg::apb_data_t prdata_o;
  logic               pready_o;
  logic               pslverr_o;

  // Reference model state
  mem_pkg::mem_word_t model_mem [WORDS];
  mem_pkg::mem_hi_t   model_stage;
  logic [1:0]         model_stage_mask;  // Lanes 4 and 5
  mem_pkg::mem_hi_t   model_hold;

  int err_cnt        = 0;
  int timing_err_cnt = 0;
  int stray_cnt      = 0;
  int xfer_cnt       = 0;
  int ready_cnt      = 0;
  int cycle_cnt      = 0;

  apb_mem_top i_dut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Every PREADY must fall inside an access phase
  always @(posedge clk_i) begin
    if (rst_n_i && pready_o) begin
      ready_cnt++;
      if (!(psel_i && penable_i)) begin
        $display("PREADY seen at %0t ns outside an access phase", $time);
        stray_cnt++;
      end
    end
  end

  function automatic apb_pkg::apb_addr_t word_addr(input mem_pkg::mem_addr_t idx,
                                                   input logic hi);
    return {3'b000, idx, hi, 2'b00};
  endfunction

  // Access kind from the address map
  function automatic apb_pkg::access_kind_e expected_kind(input logic wr,
                                                         input apb_pkg::apb_addr_t addr);
    if (addr[1:0] != 2'b00 || addr[11:9] != 3'b000) begin
      return apb_pkg::ACC_ERR;
    end
    if (wr) begin
      if (addr[2]) return apb_pkg::ACC_WR_HI;
      return apb_pkg::ACC_WR_LO;
    end
    if (addr[2]) return apb_pkg::ACC_RD_HI;
    return apb_pkg::ACC_RD_LO;
  endfunction

  // Each bit follows the enable of its byte lane
  function automatic mem_pkg::mem_word_t merge_lanes(input mem_pkg::mem_word_t old_w,
                                                     input mem_pkg::mem_word_t new_w,
                                                     input mem_pkg::lane_mask_t lanes);
    mem_pkg::mem_word_t res;
    res = old_w;
    for (int b = 0; b < `MEM_DATA_W; b++) begin
      if (lanes[b / `LANE_W]) res[b] = new_w[b];
    end
    return res;
  endfunction

  // One APB transfer with model update and checks
  task automatic transfer(input logic wr, input apb_pkg::apb_addr_t addr,
                          input apb_pkg::apb_data_t wdata, input apb_pkg::apb_strb_t strb);
    apb_pkg::access_kind_e kind;
    mem_pkg::mem_addr_t    idx;
    apb_pkg::apb_data_t    exp_data;
    apb_pkg::apb_data_t    got_data;
    logic                  got_err;
    logic                  is_read;
    int                    cycles;
    int                    exp_cycles;
    kind     = expected_kind(wr, addr);
    idx      = addr[8:3];
    is_read  = 1'b0;
    exp_data = '0;
    @(posedge clk_i);
    psel_i    <= 1'b1;  // Setup phase
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    pstrb_i   <= strb;
    @(posedge clk_i);
    penable_i <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!pready_o);
    got_data = prdata_o;
    got_err  = pslverr_o;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    xfer_cnt++;

    exp_cycles = (kind == apb_pkg::ACC_RD_LO) ? 4 : 3;
    if (cycles != exp_cycles) begin
      $display("** Error at %0t ns: PREADY in access cycle %0d, expected %0d, addr %h",
               $time, cycles, exp_cycles, addr);
      timing_err_cnt++;
    end
    if (got_err !== (kind == apb_pkg::ACC_ERR)) begin
      $display("** Error at %0t ns: PSLVERR %b for addr %h", $time, got_err, addr);
      err_cnt++;
    end

    case (kind)
      apb_pkg::ACC_WR_HI: begin
        model_stage      = wdata[`HI_W-1:0];
        model_stage_mask = strb[1:0];
      end
      apb_pkg::ACC_WR_LO: begin
        model_mem[idx] = merge_lanes(model_mem[idx], {model_stage, wdata},
                                     {model_stage_mask, strb});
        model_stage_mask = '0;
      end
      apb_pkg::ACC_RD_LO: begin
        is_read    = 1'b1;
        exp_data   = model_mem[idx][`APB_DATA_W-1:0];
        model_hold = model_mem[idx][`MEM_DATA_W-1:`APB_DATA_W];
      end
      apb_pkg::ACC_RD_HI: begin
        is_read  = 1'b1;
        exp_data = {{PAD_W{1'b0}}, model_hold};
      end
      default: ;  // Errors leave the model alone
    endcase

    if (is_read && got_data !== exp_data) begin
      $display("** Error at %0t ns: PRDATA %h, expected %h, addr %h",
               $time, got_data, exp_data, addr);
      err_cnt++;
    end
  endtask

  initial begin
    logic [31:0]        rnd;
    logic               wr;
    apb_pkg::apb_addr_t addr;
    apb_pkg::apb_strb_t strb;
    rnd       = $urandom(32'h7993);
    rst_n_i   = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    pstrb_i   = '0;
    model_stage      = '0;
    model_stage_mask = '0;
    model_hold       = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;

    transfer(1'b0, word_addr(6'd0, 1'b1), '0, '0);  // Holding register still zero

    // Fill every word so no read sees an unwritten macro entry
    for (int w = 0; w < WORDS; w++) begin
      transfer(1'b1, word_addr(w[5:0], 1'b1), $urandom(), 4'b0011);
      transfer(1'b1, word_addr(w[5:0], 1'b0), $urandom(), 4'hF);
    end

    // Full 46-bit round trip
    transfer(1'b1, word_addr(6'd5, 1'b1), 32'h0000_2ABC, 4'hF);
    transfer(1'b1, word_addr(6'd5, 1'b0), 32'hDEAD_BEEF, 4'hF);
    transfer(1'b0, word_addr(6'd5, 1'b0), '0, '0);
    transfer(1'b0, word_addr(6'd5, 1'b1), '0, '0);

    // Partial lanes with nothing staged first
    transfer(1'b1, word_addr(6'd5, 1'b0), 32'h1234_5678, 4'b0101);
    transfer(1'b0, word_addr(6'd5, 1'b0), '0, '0);
    transfer(1'b0, word_addr(6'd5, 1'b1), '0, '0);
    transfer(1'b1, word_addr(6'd5, 1'b1), 32'h0000_1555, 4'b0010);
    transfer(1'b1, word_addr(6'd5, 1'b0), 32'hA5A5_C3C3, 4'b0010);
    transfer(1'b0, word_addr(6'd5, 1'b0), '0, '0);
    transfer(1'b0, word_addr(6'd5, 1'b1), '0, '0);

    // Holding register keeps the old upper bits across a write
    transfer(1'b0, word_addr(6'd7, 1'b0), '0, '0);
    transfer(1'b1, word_addr(6'd7, 1'b1), 32'h0000_3FFF, 4'hF);
    transfer(1'b1, word_addr(6'd7, 1'b0), 32'h0F0F_0F0F, 4'hF);
    transfer(1'b0, word_addr(6'd7, 1'b1), '0, '0);

    // Bad addresses leave staging, memory and the holding register alone
    transfer(1'b1, word_addr(6'd3, 1'b1), 32'h0000_0AAA, 4'hF);
    transfer(1'b1, word_addr(6'd3, 1'b1) | 12'h001, 32'h0000_1111, 4'hF);
    transfer(1'b1, word_addr(6'd3, 1'b0) | 12'h200, 32'h2222_2222, 4'hF);
    transfer(1'b0, word_addr(6'd3, 1'b0) | 12'h002, '0, '0);
    transfer(1'b0, word_addr(6'd3, 1'b1), '0, '0);
    transfer(1'b0, word_addr(6'd3, 1'b0), '0, '0);
    transfer(1'b1, word_addr(6'd3, 1'b0), 32'h7777_8888, 4'hF);
    transfer(1'b0, word_addr(6'd3, 1'b0), '0, '0);
    transfer(1'b0, word_addr(6'd3, 1'b1), '0, '0);

    for (int n = 0; n < N_RANDOM; n++) begin
      rnd  = $urandom();
      wr   = rnd[0];
      addr = word_addr(rnd[6:1], rnd[7]);
      if (rnd[11:8] == 4'd0) addr[1:0] = rnd[13:12] | 2'b01;    // Misaligned
      if (rnd[11:8] == 4'd1) addr[11:9] = rnd[14:12] | 3'b001;  // Out of range
      strb = rnd[15] ? 4'hF : rnd[19:16];
      transfer(wr, addr, $urandom(), strb);
    end

    repeat (2) @(posedge clk_i);  // Let the PREADY monitor settle
    if (ready_cnt != xfer_cnt) begin
      $display("PREADY pulse count %0d does not match transfer count %0d",
               ready_cnt, xfer_cnt);
      timing_err_cnt++;
    end
    $display("Errors: %0d data, %0d timing, %0d stray PREADY over %0d transfers",
             err_cnt, timing_err_cnt, stray_cnt, xfer_cnt);
    if (err_cnt == 0 && timing_err_cnt == 0 && stray_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/apb_pkg.sv
hdl/synthram_64x8.sv
hdl/hard_mem_1rw_d64_w46_wrapper.sv
hdl/apb_mem_decode.sv
hdl/mem_access_exec.sv
hdl/apb_mem_result.sv
hdl/apb_mem_top.sv
test/tb_apb_mem.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_apb_mem || exit 1
out=$(./obj_dir/Vtb_apb_mem)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "run.sh: simulation passed" || {
  echo "run.sh: simulation failed"
  exit 1
}
